// File: project.f
source/rx_dsp_pkg.sv
source/rx_setting_regs.sv
source/rx_gain_scale.sv
source/rx_quadrant_mixer.sv
source/rx_cic_decim.sv
source/rx_round_out.sv
source/rx_dsp_core.sv
sim/rx_dsp_core_assert.sv
sim/tb_rx_dsp_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rx dsp core testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_rx_dsp_core -f project.f
status=0
./obj_dir/Vtb_rx_dsp_core > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "Simulation finished: FAIL" sim.log; then
   exit 1
fi

// File: sim/rx_dsp_core_assert.sv
/*
 * rx dsp core strobe checks
 * bound into the core, watches output and cic strobe timing
 */
`timescale 1ns/1ns

module rx_dsp_core_assert (
   input logic       clk,
   input logic       rst,
   input logic       i_run,
   input logic       o_strobe,
   input logic       cic_stb,
   input logic [3:0] decim_m1
);

   logic [5:0] since_stb;   // clocks since last cic strobe, saturating

   always_ff @(posedge clk) begin
      if (rst)
         since_stb <= '1;
      else if (cic_stb)
         since_stb <= 6'd1;
      else if (since_stb != '1)
         since_stb <= since_stb + 6'd1;
   end

   strobe_after_stop: assert property (@(posedge clk) disable iff (rst)
      $fell(i_run) |-> ##2 !o_strobe)
      else $error("o_strobe high two cycles after run fell");

   strobe_in_reset: assert property (@(posedge clk) rst |=> !o_strobe)
      else $error("o_strobe high right after a reset cycle");

   // at least R clocks between cic outputs
   strobe_gap: assert property (@(posedge clk) disable iff (rst)
      cic_stb |-> since_stb >= 6'(decim_m1) + 6'd1)
      else $error("cic strobes closer than the decimation rate");

endmodule

bind rx_dsp_core rx_dsp_core_assert assert0 (
   .clk      (clk),
   .rst      (rst),
   .i_run    (i_run),
   .o_strobe (o_strobe),
   .cic_stb  (cic_stb),
   .decim_m1 (cfg.decim_m1)
);

// File: sim/tb_rx_dsp_core.sv
/*
 * rx dsp core testbench
 * directed tests checked against a model of the gain, rotation, cic and rounding rules
 */
`timescale 1ns/1ns

module tb_rx_dsp_core
   import rx_dsp_pkg::*;
();

   localparam int BASE = 160;

   logic        clk;
   logic        rst;
   set_bus_t    set_bus;
   iq18_t       adc;
   logic        run;
   iq16_t       sample;
   logic        strobe;
   int          errors;
   int          checks;
   int          cycle;
   int unsigned lcg_state;
   iq18_t       x_unity;
   iq18_t       x_pair;

   rx_dsp_core #(.BASE(BASE)) dut0 (
      .clk      (clk),
      .rst      (rst),
      .i_set    (set_bus),
      .i_adc    (adc),
      .i_run    (run),
      .o_sample (sample),
      .o_strobe (strobe)
   );

   always #2 clk = ~clk;   // 4 ns period

   always @(posedge clk)
      cycle <= cycle + 1;

   function automatic logic signed [17:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[30:13];
   endfunction

   // model of the gain rule, Q2.14 product then clamp to 18 bits
   function automatic logic signed [17:0] gain_ref(input logic signed [17:0] x,
                                                   input logic signed [15:0] g);
      longint p;
      p = (longint'(x) * longint'(g)) >>> GAIN_SHIFT;
      if (p > 131071)
         return 18'sh1FFFF;
      if (p < -131072)
         return 18'sh20000;
      return p[17:0];
   endfunction

   function automatic logic signed [17:0] neg_ref(input logic signed [17:0] x);
      return (x == 18'sh20000) ? 18'sh1FFFF : -x;   // quadrant 2 negation
   endfunction

   function automatic logic signed [15:0] round_ref(input longint y);
      longint r;
      r = (y + (longint'(1) << (OUT_SHIFT - 1))) >>> OUT_SHIFT;
      if (r > 32767)
         return 16'sh7FFF;
      if (r < -32768)
         return 16'sh8000;
      return r[15:0];
   endfunction

   // steady output at quadrant 0, cic gain R squared
   function automatic iq16_t steady_ref(input iq18_t x, input logic signed [15:0] gi,
                                        input logic signed [15:0] gq, input int rate);
      iq16_t r;
      r.i = round_ref(longint'(gain_ref(x.i, gi)) * rate * rate);
      r.q = round_ref(longint'(gain_ref(x.q, gq)) * rate * rate);
      return r;
   endfunction

   function automatic void check_value(input string name, input int got, input int exp);
      checks++;
      assert (got == exp) else begin
         $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
         errors++;
      end
   endfunction

   task automatic write_setting(input int offset, input logic [31:0] data);
      @(posedge clk);
      set_bus <= {1'b1, 8'(BASE + offset), data};
      @(posedge clk);
      set_bus <= '0;
   endtask

   // returns at the negedge where o_strobe is seen, or after limit cycles
   task automatic wait_strobe(input int limit, output bit found);
      int n;
      found = 1'b0;
      for (n = 0; n < limit && !found; n++) begin
         @(negedge clk);
         found = strobe;
      end
   endtask

   task automatic start_channel(input logic [31:0] phase_inc, input logic signed [15:0] gi,
                                input logic signed [15:0] gq, input int rate, input iq18_t x);
      @(posedge clk);
      run <= 1'b0;
      adc <= x;
      write_setting(REG_PHASE, phase_inc);
      write_setting(REG_GAIN, {gi, gq});
      write_setting(REG_DECIM, 32'(rate - 1));
      repeat (3) @(posedge clk);   // cfg, gain and mixer registers settle
      run <= 1'b1;
   endtask

   task automatic expect_steady(input int rate, input iq16_t exp, input int count);
      bit found;
      int last;
      int n;
      last = 0;
      for (n = 0; n < count + 3; n++) begin
         wait_strobe(4 * rate + 16, found);
         checks++;
         assert (found) else begin
            $display("ERROR t=%0t no o_strobe within %0d cycles", $time, 4 * rate + 16);
            errors++;
         end
         if (!found)
            return;
         if (n > 0)
            check_value("strobe spacing", cycle - last, rate);
         last = cycle;
         if (n >= 3) begin   // first three hold the cic start-up
            check_value("o_sample.i", sample.i, exp.i);
            check_value("o_sample.q", sample.q, exp.q);
         end
      end
   endtask

   task automatic expect_quiet(input int limit);
      bit found;
      wait_strobe(limit, found);
      checks++;
      assert (!found) else begin
         $display("ERROR t=%0t o_strobe pulsed while run is low", $time);
         errors++;
      end
   endtask

   task automatic reset_idle();
      expect_quiet(24);
      check_value("o_sample.i", sample.i, 0);
      check_value("o_sample.q", sample.q, 0);
   endtask

   task automatic unity_gain_rate4(input iq18_t x);
      start_channel(32'd0, 16'sd16384, 16'sd16384, 4, x);
      expect_steady(4, steady_ref(x, 16'sd16384, 16'sd16384, 4), 8);
   endtask

   task automatic unequal_gain_rate16(input iq18_t x);
      start_channel(32'd0, 16'sd8192, -16'sd16384, 16, x);
      expect_steady(16, steady_ref(x, 16'sd8192, -16'sd16384, 16), 4);
   endtask

   task automatic mixer_cancellation(input iq18_t x);
      iq16_t              exp;
      logic signed [17:0] gi;
      logic signed [17:0] gq;
      gi = gain_ref(x.i, 16'sd16384);
      gq = gain_ref(x.q, 16'sd16384);
      // quadrants 0 and 2 alternate under cic weights 1 2 1
      exp.i = round_ref(2 * longint'(gi) + 2 * longint'(neg_ref(gi)));
      exp.q = round_ref(2 * longint'(gq) + 2 * longint'(neg_ref(gq)));
      start_channel(32'h8000_0000, 16'sd16384, 16'sd16384, 2, x);
      expect_steady(2, exp, 8);
   endtask

   task automatic full_scale_saturation();
      iq18_t x;
      x.i = 18'sh20000;
      x.q = 18'sh20000;
      start_channel(32'd0, 16'sh7FFF, 16'sh8000, 16, x);
      expect_steady(16, steady_ref(x, 16'sh7FFF, 16'sh8000, 16), 4);
   endtask

   task automatic run_restart(input iq18_t x);
      @(posedge clk);
      run <= 1'b0;
      repeat (2) @(posedge clk);   // a strobe already in the round stage may still leave
      expect_quiet(40);
      unity_gain_rate4(x);
   endtask

   initial begin
      clk       = 1'b0;
      rst       = 1'b1;
      run       = 1'b0;
      set_bus   = '0;
      adc       = '0;
      errors    = 0;
      checks    = 0;
      cycle     = 0;
      lcg_state = 59062;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      x_unity.i = next_rand();
      x_unity.q = next_rand();
      reset_idle();
      unity_gain_rate4(x_unity);
      x_pair.i = next_rand();
      x_pair.q = next_rand();
      unequal_gain_rate16(x_pair);
      x_pair.i = next_rand();
      x_pair.q = next_rand();
      mixer_cancellation(x_pair);
      full_scale_saturation();
      run_restart(x_unity);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: source/rx_cic_decim.sv
/*
 * rx cic decimator, one rail
 * two integrators at input rate, two combs once per R inputs,
 * runtime rate of 1 to 16, steady gain R squared
 */
`timescale 1ns/1ns

module rx_cic_decim #(
   parameter int IN_W  = 18,
   parameter int ACC_W = 26
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    i_run,
   input  logic [3:0]              i_decim_m1,
   input  logic signed [IN_W-1:0]  i_data,
   output logic signed [ACC_W-1:0] o_data,
   output logic                    o_strobe
);

   logic signed [ACC_W-1:0] in_ext;
   logic signed [ACC_W-1:0] integ1;
   logic signed [ACC_W-1:0] integ2;
   logic signed [ACC_W-1:0] comb1_dly;
   logic signed [ACC_W-1:0] comb2_dly;
   logic signed [ACC_W-1:0] comb1;
   logic signed [ACC_W-1:0] comb2;
   logic [3:0]              cnt;
   logic                    dump;

   assign in_ext = i_data;   // sign extend

   // >= so a rate lowered mid run does not wrap through 15
   assign dump = (cnt >= i_decim_m1);

   // comb differences, wrap arithmetic is intended
   assign comb1 = integ2 - comb1_dly;
   assign comb2 = comb1 - comb2_dly;

   always_ff @(posedge clk) begin
      if (rst || !i_run) begin
         integ1    <= '0;
         integ2    <= '0;
         comb1_dly <= '0;
         comb2_dly <= '0;
         cnt       <= '0;
         o_data    <= '0;
         o_strobe  <= 1'b0;
      end else begin
         integ1   <= integ1 + in_ext;
         integ2   <= integ2 + integ1;
         o_strobe <= dump;   // once every R clocks
         if (dump) begin
            cnt       <= '0;
            comb1_dly <= integ2;
            comb2_dly <= comb1;
            o_data    <= comb2;
         end else begin
            cnt <= cnt + 4'd1;
         end
      end
   end

endmodule

// File: source/rx_dsp_core.sv
/*
 * rx dsp core, one receive channel
 * settings, gain, quadrant mixer, cic decimation and rounding to 16 bit I/Q
 */
`timescale 1ns/1ns

module rx_dsp_core
   import rx_dsp_pkg::*;
#(
   parameter int BASE = 160
) (
   input  logic     clk,
   input  logic     rst,
   input  set_bus_t i_set,
   input  iq18_t    i_adc,
   input  logic     i_run,
   output iq16_t    o_sample,
   output logic     o_strobe
);

   rx_cfg_t cfg;
   iq18_t   scaled;
   iq18_t   mixed;
   iq26_t   cic_data;   // decimated I/Q rails
   logic    cic_stb;

   rx_setting_regs #(.BASE(BASE)) regs0 (
      .clk   (clk),
      .rst   (rst),
      .i_set (i_set),
      .o_cfg (cfg)
   );

   rx_gain_scale gain0 (
      .clk      (clk),
      .rst      (rst),
      .i_adc    (i_adc),
      .i_gain_i (cfg.gain_i),
      .i_gain_q (cfg.gain_q),
      .o_iq     (scaled)
   );

   rx_quadrant_mixer mix0 (
      .clk         (clk),
      .rst         (rst),
      .i_run       (i_run),
      .i_phase_inc (cfg.phase_inc),
      .i_iq        (scaled),
      .o_iq        (mixed)
   );

   rx_cic_decim #(.IN_W(18), .ACC_W(26)) cic_i (
      .clk        (clk),
      .rst        (rst),
      .i_run      (i_run),
      .i_decim_m1 (cfg.decim_m1),
      .i_data     (mixed.i),
      .o_data     (cic_data.i),
      .o_strobe   (cic_stb)
   );

   // shares rate and run with cic_i so its strobe stays open
   rx_cic_decim #(.IN_W(18), .ACC_W(26)) cic_q (
      .clk        (clk),
      .rst        (rst),
      .i_run      (i_run),
      .i_decim_m1 (cfg.decim_m1),
      .i_data     (mixed.q),
      .o_data     (cic_data.q),
      .o_strobe   ()
   );

   rx_round_out round0 (
      .clk      (clk),
      .rst      (rst),
      .i_strobe (cic_stb),
      .i_i      (cic_data.i),
      .i_q      (cic_data.q),
      .o_sample (o_sample),
      .o_strobe (o_strobe)
   );

endmodule

// File: source/rx_dsp_pkg.sv
/*
 * rx dsp shared types
 * sample pairs, settings bus, channel configuration and register map
 */
package rx_dsp_pkg;

   typedef struct packed {
      logic signed [17:0] i;
      logic signed [17:0] q;
   } iq18_t;   // adc side pair

   typedef struct packed {
      logic signed [25:0] i;
      logic signed [25:0] q;
   } iq26_t;   // cic internal pair

   typedef struct packed {
      logic signed [15:0] i;
      logic signed [15:0] q;
   } iq16_t;   // output pair

   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   typedef struct packed {
      logic [31:0]        phase_inc;
      logic signed [15:0] gain_i;     // Q2.14
      logic signed [15:0] gain_q;     // Q2.14
      logic [3:0]         decim_m1;   // rate minus one
   } rx_cfg_t;

   // register offsets from base
   localparam int REG_PHASE = 0;
   localparam int REG_GAIN  = 1;
   localparam int REG_DECIM = 2;

   localparam int GAIN_SHIFT = 14;   // gain fraction bits
   localparam int OUT_SHIFT  = 10;   // bits dropped at output

endpackage

// File: source/rx_gain_scale.sv
/*
 * rx gain stage
 * scales I and Q by signed Q2.14 gains and saturates to 18 bits
 */
`timescale 1ns/1ns

module rx_gain_scale
   import rx_dsp_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  iq18_t              i_adc,
   input  logic signed [15:0] i_gain_i,
   input  logic signed [15:0] i_gain_q,
   output iq18_t              o_iq
);

   localparam logic signed [33:0] SAT_HI = 34'sd131071;
   localparam logic signed [33:0] SAT_LO = -34'sd131072;

   // one multiplier rail, full product then shift and clamp
   function automatic logic signed [17:0] scale_sat(input logic signed [17:0] x,
                                                    input logic signed [15:0] g);
      logic signed [33:0] prod;
      logic signed [33:0] shifted;
      prod    = x * g;
      shifted = prod >>> GAIN_SHIFT;
      if (shifted > SAT_HI)
         return 18'sh1FFFF;
      else if (shifted < SAT_LO)
         return 18'sh20000;
      return shifted[17:0];
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         o_iq <= '0;
      end else begin
         o_iq.i <= scale_sat(i_adc.i, i_gain_i);
         o_iq.q <= scale_sat(i_adc.q, i_gain_q);
      end
   end

endmodule

// File: source/rx_quadrant_mixer.sv
/*
 * rx quadrant mixer
 * phase accumulator plus exact I/Q rotation in 90 degree steps
 */
`timescale 1ns/1ns

module rx_quadrant_mixer
   import rx_dsp_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        i_run,
   input  logic [31:0] i_phase_inc,
   input  iq18_t       i_iq,
   output iq18_t       o_iq
);

   logic [31:0] phase;
   iq18_t       rotated;

   // -(-131072) has no 18 bit form, clamp it
   function automatic logic signed [17:0] neg_sat(input logic signed [17:0] x);
      if (x == 18'sh20000)
         return 18'sh1FFFF;
      return -x;
   endfunction

   // quadrant from the phase held before this cycle's add
   always_comb begin
      case (phase[31:30])
         2'd0: begin
            rotated.i = i_iq.i;
            rotated.q = i_iq.q;
         end
         2'd1: begin
            rotated.i = neg_sat(i_iq.q);
            rotated.q = i_iq.i;
         end
         2'd2: begin
            rotated.i = neg_sat(i_iq.i);
            rotated.q = neg_sat(i_iq.q);
         end
         default: begin
            rotated.i = i_iq.q;
            rotated.q = neg_sat(i_iq.i);
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         phase <= '0;
         o_iq  <= '0;
      end else begin
         if (!i_run)
            phase <= '0;   // first sample after run uses quadrant 0
         else
            phase <= phase + i_phase_inc;
         o_iq <= rotated;
      end
   end

endmodule

// File: source/rx_round_out.sv
/*
 * rx output rounding
 * rounds half up, saturates to 16 bits and delays the strobe one cycle
 */
`timescale 1ns/1ns

module rx_round_out
   import rx_dsp_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic               i_strobe,
   input  logic signed [25:0] i_i,
   input  logic signed [25:0] i_q,
   output iq16_t              o_sample,
   output logic               o_strobe
);

   localparam logic signed [26:0] OUT_MAX  = 27'sd32767;
   localparam logic signed [26:0] OUT_MIN  = -27'sd32768;
   localparam logic signed [26:0] HALF_LSB = 27'sd1 <<< (OUT_SHIFT - 1);

   function automatic logic signed [15:0] round_sat(input logic signed [25:0] x);
      logic signed [26:0] biased;
      logic signed [26:0] shifted;
      biased  = x;   // one guard bit for the add
      biased  = biased + HALF_LSB;
      shifted = biased >>> OUT_SHIFT;
      if (shifted > OUT_MAX)
         return 16'sh7FFF;
      else if (shifted < OUT_MIN)
         return 16'sh8000;
      return shifted[15:0];
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         o_sample <= '0;
         o_strobe <= 1'b0;
      end else begin
         o_strobe <= i_strobe;
         if (i_strobe) begin   // hold between outputs
            o_sample.i <= round_sat(i_i);
            o_sample.q <= round_sat(i_q);
         end
      end
   end

endmodule

// File: source/rx_setting_regs.sv
/*
 * rx settings registers
 * decodes settings bus writes at BASE into the channel configuration
 */
`timescale 1ns/1ns

module rx_setting_regs
   import rx_dsp_pkg::*;
#(
   parameter int BASE = 160
) (
   input  logic     clk,
   input  logic     rst,
   input  set_bus_t i_set,
   output rx_cfg_t  o_cfg
);

   localparam logic [7:0] ADDR_PHASE = 8'(BASE + REG_PHASE);
   localparam logic [7:0] ADDR_GAIN  = 8'(BASE + REG_GAIN);
   localparam logic [7:0] ADDR_DECIM = 8'(BASE + REG_DECIM);

   logic wr_phase;
   logic wr_gain;
   logic wr_decim;

   assign wr_phase = i_set.stb && (i_set.addr == ADDR_PHASE);
   assign wr_gain  = i_set.stb && (i_set.addr == ADDR_GAIN);
   assign wr_decim = i_set.stb && (i_set.addr == ADDR_DECIM);

   always_ff @(posedge clk) begin
      if (rst) begin
         o_cfg <= '0;   // R = 1, gain 0
      end else begin
         if (wr_phase)
            o_cfg.phase_inc <= i_set.data;
         if (wr_gain) begin
            o_cfg.gain_i <= i_set.data[31:16];
            o_cfg.gain_q <= i_set.data[15:0];
         end
         if (wr_decim)
            o_cfg.decim_m1 <= i_set.data[3:0];
      end
   end

endmodule
